//--- sources.f
+incdir+verilog
verilog/sram_pkg.sv
verilog/wb_if.sv
verilog/cmd_fifo.sv
verilog/wb_initiator.sv
verilog/sram_ctrl.sv
verilog/sram_subsystem.sv
verification/sram_model.sv
verification/tb_sram_subsystem.sv

//--- verification/sram_model.sv
/*
 * Behavioral 32 KiB asynchronous SRAM, 8-bit words
 * Write latches at the end of the WE pulse, read data follows OE
 */
`timescale 1ns/1ps
`include "sram_macros.svh"

module sram_model (
    input  logic                         oe_i,
    input  logic                         we_i,
    input  logic                         data_oe_i,
    input  logic [`SRAM_ADDR_WIDTH-1:0]  addr_i,
    input  logic [`SRAM_DATA_WIDTH-1:0]  data_i,
    output logic [`SRAM_DATA_WIDTH-1:0]  data_o
);
    localparam int DEPTH = 1 << `SRAM_ADDR_WIDTH;

    // Storage array
    logic [`SRAM_DATA_WIDTH-1:0] mem [DEPTH];

    // Power-up contents, every address bit shows up in the pattern
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = 8'(i ^ (i >> 7));
        end
    end

    // Address and data are still held by the controller when WE falls
    always @(negedge we_i) begin
        mem[addr_i] <= data_i;
    end

    // Output driver only while OE is high and the controller is not driving
    // Delay stands in for the access time
    assign #(`SRAM_READ_NS) data_o = (oe_i && !data_oe_i) ? mem[addr_i] : 'z;

endmodule

//--- verification/tb_sram_subsystem.sv
/*
 * Testbench for the SRAM subsystem
 * Clock, reset, stimulus table, response scoreboard and SRAM strobe checks
 */
`timescale 1ns/1ps
`include "sram_macros.svh"

module tb_sram_subsystem;
    localparam logic [31:0] SEED          = 32'ha14152bb;
    localparam int          READY_TIMEOUT = 200;
    localparam int          RSP_TIMEOUT   = 1000;
    // Accept edge to ack edge, for reads and writes alike
    localparam int          STROBE_CYCLES = 4;

    // One table row, exp only matters for reads
    typedef struct packed {
        logic                        we;
        logic [`WB_ADDR_WIDTH-1:0]   addr;
        logic [`SRAM_DATA_WIDTH-1:0] data;
        logic [`SRAM_DATA_WIDTH-1:0] exp;
    } stim_t;

    // SRAM access expected on the pins
    typedef struct packed {
        logic                        we;
        logic [`SRAM_ADDR_WIDTH-1:0] addr;
        logic [`SRAM_DATA_WIDTH-1:0] data;
    } access_t;

    logic                         wb_clock_i;
    logic                         rst_n_i;
    logic                         host_valid_i;
    logic                         host_ready_o;
    logic                         host_we_i;
    logic [`WB_ADDR_WIDTH-1:0]    host_addr_i;
    logic [`SRAM_DATA_WIDTH-1:0]  host_data_i;
    logic                         rsp_valid_o;
    logic [`SRAM_DATA_WIDTH-1:0]  rsp_data_o;
    logic                         ram_oe_o;
    logic                         ram_we_o;
    logic                         ram_data_oe_o;
    logic [`SRAM_ADDR_WIDTH-1:0]  ram_addr_o;
    logic [`SRAM_DATA_WIDTH-1:0]  ram_data_o;
    logic [`SRAM_DATA_WIDTH-1:0]  ram_rdata;

    stim_t                       stim_table [$];
    logic [`SRAM_DATA_WIDTH-1:0] rsp_exp_q [$];
    access_t                     access_q [$];
    access_t                     cur_acc;
    int                          we_cycles        = 0;
    int                          oe_cycles        = 0;
    logic                        saw_backpressure = 1'b0;

    sram_subsystem dut_i (
        .wb_clock_i    (wb_clock_i),
        .rst_n_i       (rst_n_i),
        .host_valid_i  (host_valid_i),
        .host_ready_o  (host_ready_o),
        .host_we_i     (host_we_i),
        .host_addr_i   (host_addr_i),
        .host_data_i   (host_data_i),
        .rsp_valid_o   (rsp_valid_o),
        .rsp_data_o    (rsp_data_o),
        .ram_oe_o      (ram_oe_o),
        .ram_we_o      (ram_we_o),
        .ram_data_oe_o (ram_data_oe_o),
        .ram_addr_o    (ram_addr_o),
        .ram_data_o    (ram_data_o),
        .ram_data_i    (ram_rdata)
    );

    sram_model sram_model_i (
        .oe_i      (ram_oe_o),
        .we_i      (ram_we_o),
        .data_oe_i (ram_data_oe_o),
        .addr_i    (ram_addr_o),
        .data_i    (ram_data_o),
        .data_o    (ram_rdata)
    );

    // 20 ns clock
    initial begin
        wb_clock_i = 1'b0;
        forever #10 wb_clock_i = ~wb_clock_i;
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERROR: %s is %h, expected %h", name, actual, expected);
            $display("Test failures found");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Test failures found");
        $fatal(1, "run aborted");
    endtask

    task automatic add_entry(input logic we, input logic [`WB_ADDR_WIDTH-1:0] addr,
                             input logic [7:0] data, input logic [7:0] exp);
        stim_t s;
        s = '{we: we, addr: addr, data: data, exp: exp};
        stim_table.push_back(s);
    endtask

    // Two cycles of reset, then the idle state of the outputs
    task automatic apply_reset();
        rst_n_i      = 1'b0;
        host_valid_i = 1'b0;
        repeat (2) @(posedge wb_clock_i);
        #1 rst_n_i = 1'b1;
        @(negedge wb_clock_i);
        check_value("rsp_valid_o", rsp_valid_o, 0);
        check_value("ram_oe_o", ram_oe_o, 0);
        check_value("ram_we_o", ram_we_o, 0);
        check_value("ram_data_oe_o", ram_data_oe_o, 0);
        // Ready stays low until the first edge after reset
        check_value("host_ready_o", host_ready_o, 0);
        @(posedge wb_clock_i);
        #1;
    endtask

    // Entered and left 1 ns after a rising edge
    task automatic push_cmd(input stim_t s);
        int      waited;
        access_t acc;
        waited       = 0;
        host_valid_i = 1'b1;
        host_we_i    = s.we;
        host_addr_i  = s.addr;
        host_data_i  = s.data;
        @(negedge wb_clock_i);
        while (!host_ready_o) begin
            saw_backpressure = 1'b1;
            if (waited >= READY_TIMEOUT) begin
                report_failure("host_ready_o stayed low, command could not be pushed");
            end else begin
                waited++;
                @(negedge wb_clock_i);
            end
        end
        // Handshake on this edge
        @(posedge wb_clock_i);
        #1;
        if (!s.we) begin
            rsp_exp_q.push_back(s.exp);
        end
        // RAM region is where address bits 16 and 15 are both zero
        if (s.addr[16:15] == 2'b00) begin
            acc = '{we: s.we, addr: s.addr[14:0], data: s.data};
            access_q.push_back(acc);
        end
    endtask

    task automatic apply_range(input int first, input int last);
        for (int i = first; i <= last; i++) begin
            push_cmd(stim_table[i]);
        end
        host_valid_i = 1'b0;
    endtask

    task automatic wait_responses();
        int waited;
        waited = 0;
        while (rsp_exp_q.size() != 0) begin
            if (waited >= RSP_TIMEOUT) begin
                report_failure("read responses did not all arrive in time");
            end else begin
                waited++;
                @(posedge wb_clock_i);
            end
        end
        @(posedge wb_clock_i);
        #1;
    endtask

    // Response scoreboard, reads complete in command order
    always @(negedge wb_clock_i) begin
        if (rst_n_i !== 1'b1) begin
            rsp_exp_q.delete();
        end else if (rsp_valid_o) begin
            if (rsp_exp_q.size() == 0) begin
                report_failure("rsp_valid_o pulsed with no read outstanding");
            end else begin
                check_value("rsp_data_o", rsp_data_o, rsp_exp_q.pop_front());
            end
        end
    end

    // SRAM pin monitor
    always @(negedge wb_clock_i) begin
        if (rst_n_i !== 1'b1) begin
            we_cycles = 0;
            oe_cycles = 0;
            access_q.delete();
        end else begin
            check_value("ram_oe_o & ram_we_o", ram_oe_o & ram_we_o, 0);
            if (ram_we_o || ram_oe_o) begin
                // First cycle of a strobe takes the next mapped command
                if (we_cycles == 0 && oe_cycles == 0) begin
                    if (access_q.size() == 0) begin
                        report_failure("SRAM strobe rose with no mapped command pending");
                    end else begin
                        cur_acc = access_q.pop_front();
                    end
                end
                check_value("ram_we_o", ram_we_o, cur_acc.we);
                // Data bus driven for writes only
                check_value("ram_data_oe_o", ram_data_oe_o, cur_acc.we);
                check_value("ram_addr_o", ram_addr_o, cur_acc.addr);
                if (ram_we_o) begin
                    check_value("ram_data_o", ram_data_o, cur_acc.data);
                end
            end else begin
                check_value("ram_data_oe_o", ram_data_oe_o, 0);
            end
            if (ram_we_o) begin
                we_cycles++;
            end else if (we_cycles != 0) begin
                check_value("ram_we_o high cycles", we_cycles, STROBE_CYCLES);
                we_cycles = 0;
            end
            if (ram_oe_o) begin
                oe_cycles++;
            end else if (oe_cycles != 0) begin
                check_value("ram_oe_o high cycles", oe_cycles, STROBE_CYCLES);
                oe_cycles = 0;
            end
        end
    end

    initial begin
        int                          burst_first;
        int                          reset_first;
        int                          after_first;
        logic [`SRAM_DATA_WIDTH-1:0] burst_data [4];
        rst_n_i      = 1'b0;
        host_valid_i = 1'b0;
        host_we_i    = 1'b0;
        host_addr_i  = '0;
        host_data_i  = '0;
        void'($urandom(SEED));

        // Read after write, both ends of the RAM, overwrite
        add_entry(1'b1, 17'h00000, 8'h5A, 8'h00);
        add_entry(1'b1, 17'h07FFF, 8'hC3, 8'h00);
        add_entry(1'b1, 17'h01234, 8'h77, 8'h00);
        add_entry(1'b1, 17'h00000, 8'hA5, 8'h00);
        add_entry(1'b0, 17'h00000, 8'h00, 8'hA5);
        add_entry(1'b0, 17'h07FFF, 8'h00, 8'hC3);
        add_entry(1'b0, 17'h01234, 8'h00, 8'h77);
        // Unmapped region reads FF, a write there must not alias to 0
        add_entry(1'b0, 17'h08000, 8'h00, 8'hFF);
        add_entry(1'b0, 17'h1FFFF, 8'h00, 8'hFF);
        add_entry(1'b1, 17'h08000, 8'h99, 8'h00);
        add_entry(1'b0, 17'h00000, 8'h00, 8'hA5);
        add_entry(1'b0, 17'h10000, 8'h00, 8'hFF);
        // Known contents for the reset test
        add_entry(1'b1, 17'h00101, 8'h22, 8'h00);
        add_entry(1'b1, 17'h00102, 8'h33, 8'h00);
        add_entry(1'b1, 17'h00103, 8'h44, 8'h00);
        add_entry(1'b0, 17'h00103, 8'h00, 8'h44);

        // Back to back burst, writes then reads of the same words
        burst_first = stim_table.size();
        for (int i = 0; i < 4; i++) begin
            burst_data[i] = 8'($urandom);
            add_entry(1'b1, 17'h00200 + 17'(i), burst_data[i], 8'h00);
        end
        for (int i = 0; i < 4; i++) begin
            add_entry(1'b0, 17'h00200 + 17'(i), 8'h00, burst_data[i]);
        end

        // First write is in flight at reset, the other three are still queued
        reset_first = stim_table.size();
        for (int i = 0; i < 4; i++) begin
            add_entry(1'b1, 17'h00100 + 17'(i), 8'hE0 + 8'(i), 8'h00);
        end
        after_first = stim_table.size();
        add_entry(1'b0, 17'h00101, 8'h00, 8'h22);
        add_entry(1'b0, 17'h00102, 8'h00, 8'h33);
        add_entry(1'b0, 17'h00103, 8'h00, 8'h44);

        apply_reset();
        apply_range(0, burst_first - 1);
        wait_responses();

        saw_backpressure = 1'b0;
        apply_range(burst_first, reset_first - 1);
        wait_responses();
        if (!saw_backpressure) begin
            report_failure("host_ready_o never dropped while the queue was full");
        end

        apply_range(reset_first, after_first - 1);
        apply_reset();
        apply_range(after_first, stim_table.size() - 1);
        wait_responses();

        $display("All tests passed!");
        $finish;
    end

endmodule

//--- verilog/cmd_fifo.sv
/*
 * Command queue between the host port and the Wishbone initiator
 * Circular buffer with wrap-bit pointers, valid/ready on both sides
 */
`timescale 1ns/1ps
`include "sram_macros.svh"

module cmd_fifo (
    input  logic                wb_clock_i,
    input  logic                rst_n_i,

    // Host side
    input  logic                push_valid_i,
    output logic                push_ready_o,
    input  sram_pkg::sram_cmd_t push_cmd_i,

    // Initiator side
    output logic                pop_valid_o,
    input  logic                pop_ready_i,
    output sram_pkg::sram_cmd_t pop_cmd_o
);
    localparam int PTR_W = $clog2(`CMD_FIFO_DEPTH);

    // Entry storage
    sram_pkg::sram_cmd_t entries [`CMD_FIFO_DEPTH];

    // Pointers carry one extra bit to tell full from empty
    logic [PTR_W:0] wr_ptr;
    logic [PTR_W:0] rd_ptr;
    logic           full;
    logic           empty;
    logic           push;
    logic           pop;
    // Holds ready low until the first edge after reset
    logic           ready_en;

    // Same slot, opposite lap
    assign full  = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                   (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);
    // Same slot, same lap
    assign empty = (wr_ptr == rd_ptr);

    assign push_ready_o = ready_en && !full;
    assign pop_valid_o  = !empty;

    // Head of the queue is always visible to the initiator
    assign pop_cmd_o = entries[rd_ptr[PTR_W-1:0]];

    // Handshakes, both may happen on one edge
    assign push = push_valid_i && push_ready_o;
    assign pop  = pop_ready_i && pop_valid_o;

    always_ff @(posedge wb_clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            ready_en <= 1'b0;
        end else begin
            ready_en <= 1'b1;
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Storage write, contents are don't-care until pushed
    always_ff @(posedge wb_clock_i) begin
        if (push) begin
            entries[wr_ptr[PTR_W-1:0]] <= push_cmd_i;
        end
    end

endmodule

//--- verilog/sram_ctrl.sv
/*
 * Wishbone peripheral for an asynchronous 8-bit SRAM
 * Turns each bus request into a timed OE or WE strobe on the SRAM pins
 */
`timescale 1ns/1ps
`include "sram_macros.svh"

module sram_ctrl (
    input  logic                         wb_clock_i,
    input  logic                         rst_n_i,

    // Wishbone bus
    wb_if.peripheral                     wb,

    // SRAM pins, data bus split into in, out and output enable
    output logic                         ram_oe_o,
    output logic                         ram_we_o,
    output logic                         ram_data_oe_o,
    output logic [`SRAM_ADDR_WIDTH-1:0]  ram_addr_o,
    output logic [`SRAM_DATA_WIDTH-1:0]  ram_data_o,
    input  logic [`SRAM_DATA_WIDTH-1:0]  ram_data_i
);
    // Extra cycles to hold the strobe after the accept edge
    // Read covers tAA and tOE, write covers the WE pulse width
    localparam int READ_HOLD  = sram_pkg::ns_to_cycles(`SRAM_READ_NS);
    localparam int WRITE_HOLD = sram_pkg::ns_to_cycles(`SRAM_WRITE_NS);
    localparam int HOLD_MAX   = (READ_HOLD > WRITE_HOLD) ? READ_HOLD : WRITE_HOLD;
    localparam int CNT_W      = $clog2(HOLD_MAX + 1);

    // One-hot states
    typedef enum logic [3:0] {
        ST_READY   = 4'b0001,
        ST_READING = 4'b0010,
        ST_HIGHZ   = 4'b0100,
        ST_WRITING = 4'b1000
    } state_t;

    state_t             state;
    logic [CNT_W-1:0]   cycle_count;
    logic               accept;

    // New request only when idle and not stalling
    assign accept = (state == ST_READY) && wb.cyc && wb.stb && wb.sel && !wb.stall;

    // Drive the data bus for the whole write pulse
    assign ram_data_oe_o = ram_we_o;

    always_ff @(posedge wb_clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state       <= ST_READY;
            cycle_count <= '0;
            wb.ack      <= 1'b0;
            wb.stall    <= 1'b0;
            ram_oe_o    <= 1'b0;
            ram_we_o    <= 1'b0;
        end else begin
            case (state)
                ST_READY: begin
                    wb.ack <= 1'b0;
                    if (accept) begin
                        cycle_count <= '0;
                        wb.stall    <= 1'b1;
                        // Strobes start together with the address
                        ram_oe_o    <= !wb.we;
                        ram_we_o    <= wb.we;
                        state       <= wb.we ? ST_WRITING : ST_READING;
                    end
                end
                ST_READING: begin
                    if (cycle_count == CNT_W'(READ_HOLD)) begin
                        // Data valid now, end the read
                        wb.ack   <= 1'b1;
                        ram_oe_o <= 1'b0;
                        state    <= ST_HIGHZ;
                    end else begin
                        cycle_count <= cycle_count + 1'b1;
                    end
                end
                ST_HIGHZ: begin
                    // Let the SRAM release the bus before the next access
                    wb.ack   <= 1'b0;
                    wb.stall <= 1'b0;
                    state    <= ST_READY;
                end
                ST_WRITING: begin
                    if (cycle_count == CNT_W'(WRITE_HOLD)) begin
                        // Pulse width met, no recovery needed after a write
                        wb.ack   <= 1'b1;
                        wb.stall <= 1'b0;
                        ram_we_o <= 1'b0;
                        state    <= ST_READY;
                    end else begin
                        cycle_count <= cycle_count + 1'b1;
                    end
                end
                default: begin
                    wb.ack   <= 1'b0;
                    wb.stall <= 1'b0;
                    ram_oe_o <= 1'b0;
                    ram_we_o <= 1'b0;
                    state    <= ST_READY;
                end
            endcase
        end
    end

    // Address and data captured at accept, read data at the end of the read
    always_ff @(posedge wb_clock_i) begin
        if (accept) begin
            ram_addr_o <= wb.adr[`SRAM_ADDR_WIDTH-1:0];
            ram_data_o <= wb.dat_w;
        end
        if (state == ST_READING && cycle_count == CNT_W'(READ_HOLD)) begin
            wb.dat_r <= ram_data_i;
        end
    end

endmodule

//--- verilog/sram_macros.svh
/*
 * Bus and data widths, clock period, SRAM access times
 * and command queue depth for the SRAM subsystem
 */
`ifndef SRAM_MACROS_SVH
`define SRAM_MACROS_SVH

// Data bus, one byte per SRAM word
`define SRAM_DATA_WIDTH 8
// 32 KiB of SRAM
`define SRAM_ADDR_WIDTH 15
// Host and Wishbone address, RAM sits at the bottom quarter
`define WB_ADDR_WIDTH 17

// Bus clock period and AS6C-class access times, all in ns
`define SRAM_CLOCK_NS 20
`define SRAM_READ_NS 55
`define SRAM_WRITE_NS 45

// Queue entries, power of two
`define CMD_FIFO_DEPTH 4
// Read value for addresses outside the RAM region
`define UNMAPPED_READ_DATA 8'hFF

`endif

//--- verilog/sram_pkg.sv
/*
 * Shared types for the SRAM subsystem
 * Host command struct and ns to clock cycle conversion
 */
`include "sram_macros.svh"

package sram_pkg;

    // One host command as it travels through the queue
    // Data only matters for writes
    typedef struct packed {
        logic                        we;
        logic [`WB_ADDR_WIDTH-1:0]   addr;
        logic [`SRAM_DATA_WIDTH-1:0] data;
    } sram_cmd_t;

    // Whole clock cycles needed to cover a delay, rounded up
    // 55 ns and 45 ns both give 3 at a 20 ns clock
    function automatic int ns_to_cycles(input int ns);
        int cycles;
        cycles = (ns + `SRAM_CLOCK_NS - 1) / `SRAM_CLOCK_NS;
        return cycles;
    endfunction

endpackage

//--- verilog/sram_subsystem.sv
/*
 * Top level of the SRAM subsystem
 * Host command queue, Wishbone initiator and SRAM controller
 */
`timescale 1ns/1ps
`include "sram_macros.svh"

module sram_subsystem (
    input  logic                         wb_clock_i,
    input  logic                         rst_n_i,

    // Host command port
    input  logic                         host_valid_i,
    output logic                         host_ready_o,
    input  logic                         host_we_i,
    input  logic [`WB_ADDR_WIDTH-1:0]    host_addr_i,
    input  logic [`SRAM_DATA_WIDTH-1:0]  host_data_i,

    // Read responses
    output logic                         rsp_valid_o,
    output logic [`SRAM_DATA_WIDTH-1:0]  rsp_data_o,

    // SRAM pins
    output logic                         ram_oe_o,
    output logic                         ram_we_o,
    output logic                         ram_data_oe_o,
    output logic [`SRAM_ADDR_WIDTH-1:0]  ram_addr_o,
    output logic [`SRAM_DATA_WIDTH-1:0]  ram_data_o,
    input  logic [`SRAM_DATA_WIDTH-1:0]  ram_data_i
);
    sram_pkg::sram_cmd_t host_cmd;
    sram_pkg::sram_cmd_t head_cmd;
    logic                head_valid;
    logic                head_ready;

    // Host fields packed into one queue entry
    assign host_cmd = '{we: host_we_i, addr: host_addr_i, data: host_data_i};

    // Internal Wishbone bus
    wb_if bus ();

    cmd_fifo cmd_fifo_i (
        .wb_clock_i   (wb_clock_i),
        .rst_n_i      (rst_n_i),
        .push_valid_i (host_valid_i),
        .push_ready_o (host_ready_o),
        .push_cmd_i   (host_cmd),
        .pop_valid_o  (head_valid),
        .pop_ready_i  (head_ready),
        .pop_cmd_o    (head_cmd)
    );

    wb_initiator wb_initiator_i (
        .wb_clock_i  (wb_clock_i),
        .rst_n_i     (rst_n_i),
        .cmd_valid_i (head_valid),
        .cmd_ready_o (head_ready),
        .cmd_i       (head_cmd),
        .wb          (bus.initiator),
        .rsp_valid_o (rsp_valid_o),
        .rsp_data_o  (rsp_data_o)
    );

    sram_ctrl sram_ctrl_i (
        .wb_clock_i    (wb_clock_i),
        .rst_n_i       (rst_n_i),
        .wb            (bus.peripheral),
        .ram_oe_o      (ram_oe_o),
        .ram_we_o      (ram_we_o),
        .ram_data_oe_o (ram_data_oe_o),
        .ram_addr_o    (ram_addr_o),
        .ram_data_o    (ram_data_o),
        .ram_data_i    (ram_data_i)
    );

endmodule

//--- verilog/wb_if.sv
/*
 * Wishbone B4 pipelined bus between the initiator and the SRAM controller
 * Single initiator, single byte lane, no error signalling
 */
`timescale 1ns/1ps
`include "sram_macros.svh"

interface wb_if;

    // Request side, driven by the initiator
    logic [`WB_ADDR_WIDTH-1:0]   adr;
    logic [`SRAM_DATA_WIDTH-1:0] dat_w;
    logic                        we;
    logic                        cyc;
    logic                        stb;
    // Address decode result, peripheral only responds when set
    logic                        sel;

    // Response side, driven by the peripheral
    logic [`SRAM_DATA_WIDTH-1:0] dat_r;
    // High while the peripheral cannot take a new request
    logic                        stall;
    // One cycle pulse ends the transaction, dat_r valid for reads
    logic                        ack;

    modport initiator (
        output adr, dat_w, we, cyc, stb, sel,
        input  dat_r, stall, ack
    );

    modport peripheral (
        input  adr, dat_w, we, cyc, stb, sel,
        output dat_r, stall, ack
    );

endinterface

//--- verilog/wb_initiator.sv
/*
 * Wishbone initiator that drains the command queue
 * Decodes the RAM region, runs one bus cycle at a time, returns read data
 */
`timescale 1ns/1ps
`include "sram_macros.svh"

module wb_initiator (
    input  logic                         wb_clock_i,
    input  logic                         rst_n_i,

    // Command queue side
    input  logic                         cmd_valid_i,
    output logic                         cmd_ready_o,
    input  sram_pkg::sram_cmd_t          cmd_i,

    // Wishbone bus
    wb_if.initiator                      wb,

    // Read responses, in command order, no back-pressure
    output logic                         rsp_valid_o,
    output logic [`SRAM_DATA_WIDTH-1:0]  rsp_data_o
);
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQUEST,
        ST_WAIT_ACK,
        ST_RESPOND
    } state_t;

    state_t              state;
    // Command currently being served
    sram_pkg::sram_cmd_t cmd_q;
    // Registered RAM region decode of cmd_q
    logic                mapped_q;
    logic                pop;
    logic                in_ram;

    // RAM occupies addresses where the bits above the SRAM address are zero
    assign in_ram = (cmd_i.addr[`WB_ADDR_WIDTH-1:`SRAM_ADDR_WIDTH] == '0);

    // Only take a new command once the last one has finished
    assign cmd_ready_o = (state == ST_IDLE);
    assign pop         = cmd_valid_i && cmd_ready_o;

    // Bus request comes straight from the state
    assign wb.cyc   = (state == ST_REQUEST) || (state == ST_WAIT_ACK);
    assign wb.stb   = (state == ST_REQUEST);
    assign wb.sel   = mapped_q;
    assign wb.adr   = cmd_q.addr;
    assign wb.dat_w = cmd_q.data;
    assign wb.we    = cmd_q.we;

    always_ff @(posedge wb_clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state       <= ST_IDLE;
            mapped_q    <= 1'b0;
            rsp_valid_o <= 1'b0;
        end else begin
            // Response is a single cycle pulse
            rsp_valid_o <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (pop) begin
                        mapped_q <= in_ram;
                        // Unmapped commands never touch the bus
                        state    <= in_ram ? ST_REQUEST : ST_RESPOND;
                    end
                end
                ST_REQUEST: begin
                    // Accepted when the peripheral is not stalling
                    if (!wb.stall) begin
                        state <= ST_WAIT_ACK;
                    end
                end
                ST_WAIT_ACK: begin
                    // Hold cyc until ack, then report reads
                    if (wb.ack) begin
                        rsp_valid_o <= !cmd_q.we;
                        state       <= ST_IDLE;
                    end
                end
                ST_RESPOND: begin
                    // Local completion of an unmapped command
                    rsp_valid_o <= !cmd_q.we;
                    state       <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Command and read data payload
    always_ff @(posedge wb_clock_i) begin
        if (pop) begin
            cmd_q <= cmd_i;
        end
        if (state == ST_WAIT_ACK && wb.ack) begin
            rsp_data_o <= wb.dat_r;
        end else if (state == ST_RESPOND) begin
            rsp_data_o <= `UNMAPPED_READ_DATA;
        end
    end

endmodule
